// ==== Makefile ====
SRCS = $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

all: run

obj_dir/Vdispatch_tb: dual_dispatch.f $(SRCS)
	verilator --binary --timing -j 0 --top-module dispatch_tb -f dual_dispatch.f

run: obj_dir/Vdispatch_tb
	./obj_dir/Vdispatch_tb | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== bench/dispatch_tb.sv ====
`timescale 1ns/10ps

module dispatch_tb import dispatch_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RAND_PAIRS = 200;
    // upper bound on instructions sent, random stream plus the directed tests
    localparam int MAX_INSTS = 2 * RAND_PAIRS + 40;
    localparam int CYCLES_PER_INST = 20;

    logic         clk = 1'b0;
    logic         rstn;
    logic         flush;
    logic         stall;
    logic         in_req;
    fetch_pair_t  in_pair;
    logic         in_ack;
    issue_slot_t  slot_a;
    issue_slot_t  slot_b;

    inst_bundle_t exp_q[$];
    issue_slot_t  prev_a = '0;
    issue_slot_t  prev_b = '0;
    issue_slot_t  held_a;
    issue_slot_t  held_b;
    logic         load_seen = 1'b0;
    logic [31:0]  rng_state;
    logic [31:0]  pc_next;
    string        test_name = "reset";
    int           errors;
    int           checks;
    int           mon_errors = 0;
    int           mon_checks = 0;
    int           test_errors0;
    int           issued = 0;
    int           pairs = 0;

    dispatch_top dispatch_top_i (
        .clk     (clk),
        .rstn    (rstn),
        .flush   (flush),
        .stall   (stall),
        .in_req  (in_req),
        .in_pair (in_pair),
        .in_ack  (in_ack),
        .slot_a  (slot_a),
        .slot_b  (slot_b)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // issued mul or dcache result not yet available to inst
    function automatic bit ref_load_use(input issue_slot_t s, input inst_bundle_t inst);
        op_class_e c;
        c = op_class_e'(s.inst.control[3:0]);
        if (!s.valid || s.inst.rd == 5'd0) begin
            return 1'b0;
        end
        if (c != OP_MUL && c != OP_DCACHE) begin
            return 1'b0;
        end
        return (s.inst.rd == inst.rj) || (s.inst.rd == inst.rk);
    endfunction

    // may older and younger leave together, given the slots loaded one cycle earlier
    function automatic bit ref_can_pair(input inst_bundle_t older, input inst_bundle_t younger,
                                        input issue_slot_t pa, input issue_slot_t pb);
        op_class_e oc;
        op_class_e yc;
        bit        dep;
        bit        arith;
        oc    = op_class_e'(older.control[3:0]);
        yc    = op_class_e'(younger.control[3:0]);
        dep   = older.rd != 5'd0 && oc != OP_BR &&
                (older.rd == younger.rj || older.rd == younger.rk ||
                 (yc == OP_BR && older.rd == younger.rd));
        arith = yc inside {OP_ALU, OP_BR, OP_DIV, OP_MUL, OP_ALU_BR};
        return !dep && arith && !ref_load_use(pa, younger) && !ref_load_use(pb, younger);
    endfunction

    function automatic inst_bundle_t make_inst(input op_class_e cls, input logic [4:0] rd,
                                               input logic [4:0] rj, input logic [4:0] rk);
        inst_bundle_t b;
        b         = '0;
        b.control = {28'd0, cls};
        b.rd      = rd;
        b.rj      = rj;
        b.rk      = rk;
        return b;
    endfunction

    function automatic inst_bundle_t rand_inst();
        logic [31:0]  r;
        inst_bundle_t b;
        r     = next_rand();
        // registers 0..7 only, so hazards come often
        b     = make_inst(op_class_e'(4'(r % 32'd9)), {2'b00, r[10:8]}, {2'b00, r[13:11]},
                          {2'b00, r[16:14]});
        b.ir  = next_rand();
        b.imm = next_rand();
        return b;
    endfunction

    function automatic void take_expected(input string slot, input inst_bundle_t act);
        inst_bundle_t want;
        mon_checks++;
        if (exp_q.size() == 0) begin
            $display("error: %s slot %s issued pc %h with nothing left to issue",
                     test_name, slot, act.pc);
            mon_errors++;
        end else begin
            want = exp_q.pop_front();
            if (want !== act) begin
                $display("error: %s slot %s expected %h actual %h", test_name, slot, want, act);
                mon_errors++;
            end
        end
    endfunction

    // slots take new issues only on edges without stall or flush
    always @(posedge clk) begin
        load_seen <= rstn && !stall && !flush;
    end

    always @(negedge clk) begin
        if (load_seen && slot_a.valid) begin
            issued++;
            take_expected("a", slot_a.inst);
            mon_checks++;
            if (ref_load_use(prev_a, slot_a.inst) || ref_load_use(prev_b, slot_a.inst)) begin
                $display("error: %s pc %h issued while its source was still loading",
                         test_name, slot_a.inst.pc);
                mon_errors++;
            end
            if (slot_b.valid) begin
                issued++;
                pairs++;
                take_expected("b", slot_b.inst);
                mon_checks++;
                if (!ref_can_pair(slot_a.inst, slot_b.inst, prev_a, prev_b)) begin
                    $display("error: %s pc %h and pc %h paired against the pairing rules",
                             test_name, slot_a.inst.pc, slot_b.inst.pc);
                    mon_errors++;
                end
            end
        end else if (load_seen && slot_b.valid) begin
            $display("error: %s slot b issued pc %h with slot a empty", test_name, slot_b.inst.pc);
            mon_errors++;
        end
        prev_a = slot_a;
        prev_b = slot_b;
    end

    task automatic expect_count(input string what, input int want, input int act);
        checks++;
        if (want != act) begin
            $display("error: %s %s expected %0d actual %0d", test_name, what, want, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_errors0 = errors + mon_errors;
    endtask

    task automatic finish_test();
        $display("test %s done, %0d errors", test_name, errors + mon_errors - test_errors0);
    endtask

    // four-phase handshake, one pair per transaction
    task automatic send_pair(input inst_bundle_t older, input inst_bundle_t younger,
                             input logic younger_valid);
        fetch_pair_t p;
        p.older         = older;
        p.older.pc      = pc_next;
        p.younger       = younger;
        p.younger.pc    = pc_next + 32'd4;
        p.younger_valid = younger_valid;
        pc_next         = pc_next + 32'd8;
        @(negedge clk);
        in_pair = p;
        in_req  = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        exp_q.push_back(p.older);
        if (younger_valid) begin
            exp_q.push_back(p.younger);
        end
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        // slots go back to bubbles
        repeat (3) @(negedge clk);
    endtask

    task automatic pair_case(input inst_bundle_t older, input inst_bundle_t younger,
                             input int want_issued, input int want_pairs);
        int issued0;
        int pairs0;
        issued0 = issued;
        pairs0  = pairs;
        send_pair(older, younger, 1'b1);
        drain();
        expect_count("issued", want_issued, issued - issued0);
        expect_count("pairs", want_pairs, pairs - pairs0);
    endtask

    initial begin
        int           issued0;
        int           sent;
        inst_bundle_t older;
        inst_bundle_t younger;
        logic         yv;
        rstn      = 1'b0;
        flush     = 1'b0;
        stall     = 1'b0;
        in_req    = 1'b0;
        in_pair   = '0;
        rng_state = 32'h838e;
        pc_next   = 32'h1000;
        errors    = 0;
        checks    = 0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        start_test("reset");
        expect_count("in_ack", 0, int'(in_ack));
        expect_count("slot valid bits", 0, int'({slot_a.valid, slot_b.valid}));
        finish_test();

        start_test("independent_pair");
        stall = 1'b1;
        send_pair(make_inst(OP_ALU, 5'd1, 5'd2, 5'd3), make_inst(OP_ALU, 5'd4, 5'd5, 5'd6), 1'b1);
        send_pair(make_inst(OP_ALU, 5'd10, 5'd11, 5'd12),
                  make_inst(OP_ALU, 5'd13, 5'd14, 5'd15), 1'b1);
        stall = 1'b0;
        drain();
        expect_count("issued", 4, issued);
        expect_count("pairs", 2, pairs);
        finish_test();

        start_test("dependency");
        pair_case(make_inst(OP_ALU, 5'd7, 5'd1, 5'd2), make_inst(OP_ALU, 5'd8, 5'd7, 5'd3), 2, 0);
        pair_case(make_inst(OP_ALU, 5'd0, 5'd1, 5'd2), make_inst(OP_ALU, 5'd8, 5'd0, 5'd3), 2, 1);
        pair_case(make_inst(OP_BR, 5'd7, 5'd1, 5'd2), make_inst(OP_ALU, 5'd8, 5'd7, 5'd3), 2, 1);
        // branch younger reads its rd
        pair_case(make_inst(OP_ALU, 5'd7, 5'd1, 5'd2), make_inst(OP_BR, 5'd7, 5'd4, 5'd5), 2, 0);
        finish_test();

        start_test("non_arith_younger");
        pair_case(make_inst(OP_ALU, 5'd1, 5'd2, 5'd3), make_inst(OP_DCACHE, 5'd4, 5'd5, 5'd6), 2, 0);
        pair_case(make_inst(OP_ALU, 5'd1, 5'd2, 5'd3), make_inst(OP_PRIV, 5'd4, 5'd5, 5'd6), 2, 0);
        pair_case(make_inst(OP_ALU, 5'd1, 5'd2, 5'd3), make_inst(OP_RDCNT, 5'd4, 5'd5, 5'd6), 2, 0);
        finish_test();

        start_test("load_use");
        pair_case(make_inst(OP_DCACHE, 5'd9, 5'd1, 5'd2), make_inst(OP_ALU, 5'd3, 5'd9, 5'd4), 2, 0);
        pair_case(make_inst(OP_MUL, 5'd10, 5'd1, 5'd2), make_inst(OP_ALU, 5'd3, 5'd4, 5'd10), 2, 0);
        finish_test();

        start_test("stall_flush");
        send_pair(make_inst(OP_ALU, 5'd7, 5'd1, 5'd2), make_inst(OP_ALU, 5'd8, 5'd7, 5'd3), 1'b1);
        while (!slot_a.valid) @(negedge clk);
        stall  = 1'b1;
        held_a = slot_a;
        held_b = slot_b;
        repeat (6) begin
            @(negedge clk);
            checks++;
            if (slot_a !== held_a || slot_b !== held_b) begin
                $display("error: %s held slots expected %h actual %h",
                         test_name, {held_a, held_b}, {slot_a, slot_b});
                errors++;
            end
        end
        send_pair(make_inst(OP_ALU, 5'd1, 5'd2, 5'd3), make_inst(OP_ALU, 5'd4, 5'd5, 5'd6), 1'b1);
        flush = 1'b1;
        exp_q.delete();
        @(negedge clk);
        flush = 1'b0;
        stall = 1'b0;
        expect_count("slot valid bits", 0, int'({slot_a.valid, slot_b.valid}));
        issued0 = issued;
        repeat (10) @(negedge clk);
        expect_count("issued after flush", 0, issued - issued0);
        finish_test();

        start_test("random_stream");
        issued0 = issued;
        sent    = 0;
        for (int i = 0; i < RAND_PAIRS; i++) begin
            older   = rand_inst();
            younger = rand_inst();
            yv      = (next_rand() & 32'h7) != 32'h0;
            send_pair(older, younger, yv);
            sent += yv ? 2 : 1;
        end
        drain();
        expect_count("issued", sent, issued - issued0);
        finish_test();

        $display("tests done, %0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // fixed cycle budget per instruction, reset included
    initial begin
        #((MAX_INSTS * CYCLES_PER_INST + 10) * CLK_PERIOD);
        $display("watchdog: run did not finish in time, handshake or dispatch is stuck");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== dual_dispatch.f ====
+incdir+verilog
verilog/dispatch_pkg.sv
verilog/pair_buffer.sv
verilog/pair_dispatcher.sv
verilog/issue_stage.sv
verilog/dispatch_top.sv
bench/dispatch_tb.sv

// ==== verilog/dispatch_defs.svh ====
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// width of pc, ir, imm and control
`define DISPATCH_XLEN 32

// architectural register index
`define REG_ADDR_W 5

`define EXCP_ARG_W 16

// instruction queue entries, a power of two
`define PAIR_BUF_DEPTH 4

`endif

// ==== verilog/dispatch_pkg.sv ====
`include "dispatch_defs.svh"

package dispatch_pkg;

    // operation class, low four bits of control
    typedef enum logic [3:0] {
        OP_ALU         = 4'd0,
        OP_BR          = 4'd1,
        OP_DIV         = 4'd2,
        OP_PRIV        = 4'd3,
        OP_MUL         = 4'd4,
        OP_DCACHE      = 4'd5,
        OP_PRIV_DCACHE = 4'd6,
        OP_RDCNT       = 4'd7,
        OP_ALU_BR      = 4'd8
    } op_class_e;

    // one decoded instruction
    typedef struct packed {
        logic [`DISPATCH_XLEN-1:0] pc;
        logic [`DISPATCH_XLEN-1:0] ir;
        logic [`DISPATCH_XLEN-1:0] imm;
        logic [`DISPATCH_XLEN-1:0] control;
        logic [`REG_ADDR_W-1:0]    rj;
        logic [`REG_ADDR_W-1:0]    rk;
        logic [`REG_ADDR_W-1:0]    rd;
        logic [`EXCP_ARG_W-1:0]    excp_arg;
    } inst_bundle_t;

    // front end payload, younger may be absent
    typedef struct packed {
        inst_bundle_t older;
        inst_bundle_t younger;
        logic         younger_valid;
    } fetch_pair_t;

    typedef struct packed {
        logic         valid;
        inst_bundle_t inst;
    } issue_slot_t;

    function automatic op_class_e op_class_of(input logic [`DISPATCH_XLEN-1:0] control);
        return op_class_e'(control[3:0]);
    endfunction

endpackage

// ==== verilog/dispatch_top.sv ====
`timescale 1ns/10ps

module dispatch_top import dispatch_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        stall,
    input  logic        in_req,
    input  fetch_pair_t in_pair,
    output logic        in_ack,
    output issue_slot_t slot_a,
    output issue_slot_t slot_b
);

    issue_slot_t head0;
    issue_slot_t head1;
    issue_slot_t next_a;
    issue_slot_t next_b;
    logic [1:0]  pop_count;

    // queue of decoded instructions
    pair_buffer pair_buffer_i (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .in_req    (in_req),
        .in_pair   (in_pair),
        .in_ack    (in_ack),
        .pop_count (pop_count),
        .head0     (head0),
        .head1     (head1)
    );

    // pairing decision, looks back at the issue registers
    pair_dispatcher pair_dispatcher_i (
        .head0     (head0),
        .head1     (head1),
        .slot_a    (slot_a),
        .slot_b    (slot_b),
        .stall     (stall),
        .next_a    (next_a),
        .next_b    (next_b),
        .pop_count (pop_count)
    );

    issue_stage issue_stage_i (
        .clk    (clk),
        .rstn   (rstn),
        .flush  (flush),
        .stall  (stall),
        .next_a (next_a),
        .next_b (next_b),
        .slot_a (slot_a),
        .slot_b (slot_b)
    );

endmodule

// ==== verilog/issue_stage.sv ====
`timescale 1ns/10ps

module issue_stage import dispatch_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        stall,
    input  issue_slot_t next_a,
    input  issue_slot_t next_b,
    output issue_slot_t slot_a,
    output issue_slot_t slot_b
);

    issue_slot_t slot_a_q;
    issue_slot_t slot_b_q;

    // slot a feeds the full-function pipe, slot b the arithmetic pipe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot_a_q <= '0;
            slot_b_q <= '0;
        end else if (flush) begin
            // flush wins over stall
            slot_a_q <= '0;
            slot_b_q <= '0;
        end else if (!stall) begin
            // a cycle with no issue loads a bubble
            slot_a_q <= next_a;
            slot_b_q <= next_b;
        end
    end

    // also read back by the dispatcher for the load-use check
    assign slot_a = slot_a_q;
    assign slot_b = slot_b_q;

endmodule

// ==== verilog/pair_buffer.sv ====
`timescale 1ns/10ps

`include "dispatch_defs.svh"

module pair_buffer import dispatch_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        in_req,
    input  fetch_pair_t in_pair,
    output logic        in_ack,
    input  logic [1:0]  pop_count,
    output issue_slot_t head0,
    output issue_slot_t head1
);

    localparam int PTR_W = $clog2(`PAIR_BUF_DEPTH);
    localparam int CNT_W = $clog2(`PAIR_BUF_DEPTH + 1);

    typedef enum logic {
        HS_IDLE,
        HS_ACK
    } hs_state_e;

    hs_state_e          hs_state;
    inst_bundle_t       mem [`PAIR_BUF_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr_p1;
    logic [PTR_W-1:0]   wr_ptr_p1;
    logic [CNT_W-1:0]   count;
    logic               room_for_pair;
    logic               capture;
    logic [1:0]         push_n;

    assign rd_ptr_p1 = rd_ptr + PTR_W'(1);
    assign wr_ptr_p1 = wr_ptr + PTR_W'(1);

    // a pair is taken only with two entries free, even if the younger is absent
    assign room_for_pair = (count <= CNT_W'(`PAIR_BUF_DEPTH - 2));
    assign capture       = (hs_state == HS_IDLE) && in_req && room_for_pair && !flush;
    assign push_n        = !capture ? 2'd0 : (in_pair.younger_valid ? 2'd2 : 2'd1);

    // ack is high from the capture edge until req is seen low
    assign in_ack = (hs_state == HS_ACK);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hs_state <= HS_IDLE;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
        end else if (flush) begin
            hs_state <= HS_IDLE;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (capture) begin
                        hs_state <= HS_ACK;
                    end
                end
                HS_ACK: begin
                    if (!in_req) begin
                        hs_state <= HS_IDLE;
                    end
                end
                default: hs_state <= HS_IDLE;
            endcase
            // the dispatcher never pops more than the valid heads
            rd_ptr <= rd_ptr + PTR_W'(pop_count);
            wr_ptr <= wr_ptr + PTR_W'(push_n);
            count  <= count + CNT_W'(push_n) - CNT_W'(pop_count);
        end
    end

    // queue storage
    always_ff @(posedge clk) begin
        if (capture) begin
            mem[wr_ptr] <= in_pair.older;
            if (in_pair.younger_valid) begin
                mem[wr_ptr_p1] <= in_pair.younger;
            end
        end
    end

    // oldest two entries
    assign head0.valid = (count >= CNT_W'(1));
    assign head0.inst  = mem[rd_ptr];
    assign head1.valid = (count >= CNT_W'(2));
    assign head1.inst  = mem[rd_ptr_p1];

endmodule

// ==== verilog/pair_dispatcher.sv ====
`timescale 1ns/10ps

module pair_dispatcher import dispatch_pkg::*; (
    input  issue_slot_t head0,
    input  issue_slot_t head1,
    input  issue_slot_t slot_a,
    input  issue_slot_t slot_b,
    input  logic        stall,
    output issue_slot_t next_a,
    output issue_slot_t next_b,
    output logic [1:0]  pop_count
);

    op_class_e class0;
    op_class_e class1;
    logic      dep;
    logic      arith1;
    logic      lu0;
    logic      lu1;
    logic      issue0;
    logic      issue1;

    // true when an issued slot is a mul or dcache whose result inst still needs
    function automatic logic load_use_hit(input issue_slot_t s, input inst_bundle_t inst);
        op_class_e c;
        c = op_class_of(s.inst.control);
        return s.valid && (c == OP_MUL || c == OP_DCACHE) && (s.inst.rd != '0) &&
               (s.inst.rd == inst.rj || s.inst.rd == inst.rk);
    endfunction

    assign class0 = op_class_of(head0.inst.control);
    assign class1 = op_class_of(head1.inst.control);

    // older writes a register the younger needs
    // a branch younger reads its rd as a source
    always_comb begin
        dep = 1'b0;
        if (head0.inst.rd != '0 && class0 != OP_BR) begin
            if (head0.inst.rd == head1.inst.rj || head0.inst.rd == head1.inst.rk) begin
                dep = 1'b1;
            end
            if (class1 == OP_BR && head0.inst.rd == head1.inst.rd) begin
                dep = 1'b1;
            end
        end
    end

    // slot b only feeds the arithmetic pipe
    always_comb begin
        case (class1)
            OP_ALU, OP_BR, OP_DIV, OP_MUL, OP_ALU_BR: arith1 = 1'b1;
            default: arith1 = 1'b0;
        endcase
    end

    // results from last cycle's issue are not ready yet
    assign lu0 = load_use_hit(slot_a, head0.inst) || load_use_hit(slot_b, head0.inst);
    assign lu1 = load_use_hit(slot_a, head1.inst) || load_use_hit(slot_b, head1.inst);

    assign issue0 = !stall && head0.valid && !lu0;
    assign issue1 = issue0 && head1.valid && !dep && arith1 && !lu1;

    always_comb begin
        next_a    = '0;
        next_b    = '0;
        pop_count = 2'd0;
        if (issue1) begin
            next_a.valid = 1'b1;
            next_a.inst  = head0.inst;
            next_b.valid = 1'b1;
            next_b.inst  = head1.inst;
            pop_count    = 2'd2;
        end else if (issue0) begin
            // older goes alone, younger waits at the head
            next_a.valid = 1'b1;
            next_a.inst  = head0.inst;
            pop_count    = 2'd1;
        end
    end

endmodule
